// File: src/path_config.svh
`ifndef PATH_CONFIG_SVH
`define PATH_CONFIG_SVH

// nodes per row and per column
`define PATH_DIM      8

// cost width, all ones means unreachable
`define PATH_COST_W   9

// byte address of the weight map, eight nibbles per word
`define PATH_MAP_BASE 32'h4000_0000

// byte address of the direction map, same packing
`define PATH_DIR_BASE 32'h4000_1000

// inactive cycles before a run counts as settled
`define PATH_QUIET    16

`endif

// File: src/path_pkg.sv
package path_pkg;

    // control register layout
    typedef struct packed {
        logic        run;
        logic        load;
        logic [19:0] rsvd;      // always zero
        logic [4:0]  start_y;
        logic [4:0]  start_x;
    } ctrl_t;

    // memory request, req is a single-cycle strobe
    typedef struct packed {
        logic        req;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        rdy;       // one cycle per transfer
        logic [31:0] rdata;
    } mem_rsp_t;

    // cheapest neighbour, clockwise from north
    typedef enum logic [3:0] {
        NONE = 4'd0,
        N    = 4'd1,
        NE   = 4'd2,
        E    = 4'd3,
        SE   = 4'd4,
        S    = 4'd5,
        SW   = 4'd6,
        W    = 4'd7,
        NW   = 4'd8
    } dir_e;

    // impassable cell
    localparam logic [3:0] WALL = 4'd15;

endpackage

// File: src/path_node.sv
`timescale 1ns/1ps
`include "path_config.svh"

module path_node (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         i_node_rst,
    input  logic                         i_clr,
    input  logic                         i_ld,
    input  logic [3:0]                   i_weight,
    input  logic [7:0][`PATH_COST_W-1:0] i_nbr_cost,   // index 0 is north
    output logic [`PATH_COST_W-1:0]      o_cost,
    output path_pkg::dir_e               o_dir,
    output logic                         o_mod
);

    localparam logic [`PATH_COST_W-1:0] INF = '1;

    logic [3:0]              weight;
    logic [`PATH_COST_W-1:0] min_cost;
    path_pkg::dir_e          min_dir;
    logic [`PATH_COST_W:0]   sum;
    logic [`PATH_COST_W-1:0] cand_cost;
    logic                    upd;

    // strict compare keeps the lowest direction code on ties
    always_comb begin
        min_cost = INF;
        min_dir  = path_pkg::NONE;
        for (int d = 0; d < 8; d++) begin
            if (i_nbr_cost[d] < min_cost) begin
                min_cost = i_nbr_cost[d];
                min_dir  = path_pkg::dir_e'(4'(d + 1));
            end
        end
    end

    assign sum       = min_cost + weight;
    assign cand_cost = (sum >= INF) ? INF : sum[`PATH_COST_W-1:0];   // saturate

    assign upd = (weight != path_pkg::WALL) && (min_cost != INF) &&
                 ((cand_cost != o_cost) || (min_dir != o_dir));

    always_ff @(posedge clk) begin
        if (i_ld) begin
            weight <= i_weight;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            o_cost <= INF;
            o_dir  <= path_pkg::NONE;
            o_mod  <= 1'b0;
        end else if (i_node_rst) begin
            o_cost <= INF;
            o_dir  <= path_pkg::NONE;
            o_mod  <= 1'b0;
        end else if (i_clr) begin
            // start node is the source of every path
            o_cost <= '0;
            o_dir  <= path_pkg::NONE;
            o_mod  <= (o_cost != '0);
        end else begin
            o_mod <= upd;
            if (upd) begin
                o_cost <= cand_cost;
                o_dir  <= min_dir;
            end
        end
    end

    a_clr_zero: assert property (@(posedge clk) disable iff (!arst_n)
        i_clr && !i_node_rst |=> o_cost == '0);

endmodule

// File: src/path_grid.sv
`timescale 1ns/1ps
`include "path_config.svh"

module path_grid #(
    parameter int DIM = `PATH_DIM
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        i_node_rst,
    input  logic                        i_start_clr,
    input  logic [4:0]                  i_start_x,
    input  logic [4:0]                  i_start_y,
    input  logic                        i_ld,
    input  logic [$clog2(DIM*DIM)-1:0]  i_node_idx,
    input  logic [3:0]                  i_ld_weight,
    output logic                        o_activity,
    output path_pkg::dir_e              o_node_dir
);

    localparam int NODES = DIM * DIM;
    localparam logic [`PATH_COST_W-1:0] INF = '1;

    // neighbour offsets in direction order, row 0 is north
    localparam int DX [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
    localparam int DY [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};

    logic [`PATH_COST_W-1:0] cost [NODES];
    path_pkg::dir_e          dir  [NODES];
    wire  [NODES-1:0]        ld;
    wire  [NODES-1:0]        clr;
    wire  [NODES-1:0]        mod;
    int                      start_idx;

    assign start_idx = int'(i_start_y) * DIM + int'(i_start_x);

    for (genvar y = 0; y < DIM; y++) begin : g_row
        for (genvar x = 0; x < DIM; x++) begin : g_col
            localparam int I = y * DIM + x;
            wire [7:0][`PATH_COST_W-1:0] nbr;

            for (genvar d = 0; d < 8; d++) begin : g_nbr
                localparam int NX = x + DX[d];
                localparam int NY = y + DY[d];
                if (NX >= 0 && NX < DIM && NY >= 0 && NY < DIM) begin : g_in
                    assign nbr[d] = cost[NY * DIM + NX];
                end else begin : g_edge
                    assign nbr[d] = INF;      // off-grid, never chosen
                end
            end

            assign ld[I]  = i_ld && (i_node_idx == I);
            assign clr[I] = i_start_clr && (start_idx == I);

            path_node i_node (
                .clk        (clk),
                .arst_n     (arst_n),
                .i_node_rst (i_node_rst),
                .i_clr      (clr[I]),
                .i_ld       (ld[I]),
                .i_weight   (i_ld_weight),
                .i_nbr_cost (nbr),
                .o_cost     (cost[I]),
                .o_dir      (dir[I]),
                .o_mod      (mod[I])
            );
        end
    end

    assign o_activity = |mod;
    assign o_node_dir = dir[i_node_idx];

    a_one_ld: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ld));

endmodule

// File: src/path_sequencer.sv
`timescale 1ns/1ps
`include "path_config.svh"

module path_sequencer (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    i_ctrl_wr,
    input  path_pkg::ctrl_t                         i_ctrl,
    output path_pkg::ctrl_t                         o_ctrl,
    output path_pkg::mem_req_t                      o_mem,
    input  path_pkg::mem_rsp_t                      i_mem,
    output logic                                    o_int_done,
    output logic                                    o_node_rst,
    output logic                                    o_start_clr,
    output logic [4:0]                              o_start_x,
    output logic [4:0]                              o_start_y,
    output logic                                    o_ld,
    output logic [$clog2(`PATH_DIM*`PATH_DIM)-1:0]  o_node_idx,
    output logic [3:0]                              o_ld_weight,
    input  logic                                    i_activity,
    input  path_pkg::dir_e                          i_node_dir
);

    localparam int NODES = `PATH_DIM * `PATH_DIM;
    localparam int IDX_W = $clog2(NODES);
    localparam int WORDS = NODES / 8;
    localparam int OFF_W = $clog2(WORDS) + 1;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FIRST_LOAD,
        ST_W_FIRST_LOAD,
        ST_LOAD_WEIGHT,
        ST_W_LOAD,
        ST_RUNNING,
        ST_PACK_DIR,
        ST_WRITE,
        ST_W_WRITE
    } state_e;

    state_e                 state_q, state_d;
    path_pkg::ctrl_t        ctrl_q;
    logic [IDX_W-1:0]       idx;        // node being loaded or packed
    logic [OFF_W-1:0]       word_off;
    logic [7:0][3:0]        data_word;
    logic [31:0]            rd_buf;     // word returned during unpack
    logic                   buf_vld;
    logic [`PATH_QUIET-1:0] history;
    logic                   pend;       // transfer outstanding
    logic                   ctrl_take;
    logic                   rd_req, wr_req;
    logic                   take_word;
    logic                   inc_idx, inc_off, clr_cnt;
    logic                   clr_load, clr_run;
    logic                   more_words, last_word, word_rdy;

    // while running, only a write that stops the run is taken
    assign ctrl_take  = i_ctrl_wr && (!ctrl_q.run || !i_ctrl.run);
    assign more_words = (word_off < WORDS);
    assign last_word  = (word_off == WORDS - 1);
    assign word_rdy   = buf_vld || i_mem.rdy;

    always_comb begin
        state_d    = state_q;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        take_word  = 1'b0;
        inc_idx    = 1'b0;
        inc_off    = 1'b0;
        clr_cnt    = 1'b0;
        clr_load   = 1'b0;
        clr_run    = 1'b0;
        o_node_rst = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (ctrl_q.load) begin
                    state_d = ST_FIRST_LOAD;
                    clr_cnt = 1'b1;
                end else if (ctrl_q.run) begin
                    state_d    = ST_RUNNING;
                    o_node_rst = 1'b1;
                end
            end
            ST_FIRST_LOAD: begin
                rd_req  = 1'b1;
                inc_off = 1'b1;
                state_d = ST_W_FIRST_LOAD;
            end
            ST_W_FIRST_LOAD, ST_W_LOAD: begin
                if (state_q == ST_W_LOAD && idx == '0) begin
                    clr_load = 1'b1;    // all nodes loaded
                    state_d  = ST_IDLE;
                end else if (word_rdy) begin
                    take_word = 1'b1;
                    rd_req    = more_words;   // prefetch the next word
                    inc_off   = more_words;
                    state_d   = ST_LOAD_WEIGHT;
                end
            end
            ST_LOAD_WEIGHT: begin
                inc_idx = 1'b1;
                if (idx[2:0] == 3'd7) begin
                    state_d = ST_W_LOAD;
                end
            end
            ST_RUNNING: begin
                if (history == '0) begin
                    clr_cnt = 1'b1;
                    state_d = ST_PACK_DIR;
                end
            end
            ST_PACK_DIR: begin
                inc_idx = 1'b1;
                if (idx[2:0] == 3'd7) begin
                    state_d = ST_WRITE;
                end
            end
            ST_WRITE: begin
                wr_req  = 1'b1;
                state_d = ST_W_WRITE;
            end
            ST_W_WRITE: begin
                if (i_mem.rdy) begin
                    if (last_word) begin
                        clr_run = 1'b1;
                        state_d = ST_IDLE;
                    end else begin
                        inc_off = 1'b1;
                        state_d = ST_PACK_DIR;
                    end
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        o_mem.req   = rd_req || wr_req;
        o_mem.wr    = wr_req;
        o_mem.addr  = (wr_req ? `PATH_DIR_BASE : `PATH_MAP_BASE) + (32'(word_off) << 2);
        o_mem.wdata = data_word;
    end

    assign o_ctrl      = ctrl_q;
    assign o_start_clr = ctrl_q.run;    // start pinned at zero for the whole run
    assign o_start_x   = ctrl_q.start_x;
    assign o_start_y   = ctrl_q.start_y;
    assign o_ld        = (state_q == ST_LOAD_WEIGHT);
    assign o_node_idx  = idx;
    assign o_ld_weight = data_word[idx[2:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ST_IDLE;
            ctrl_q     <= '0;
            idx        <= '0;
            word_off   <= '0;
            buf_vld    <= 1'b0;
            history    <= '0;
            pend       <= 1'b0;
            o_int_done <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ctrl_take) begin
                ctrl_q.run     <= i_ctrl.run;
                ctrl_q.load    <= i_ctrl.load;
                ctrl_q.start_y <= i_ctrl.start_y;
                ctrl_q.start_x <= i_ctrl.start_x;
            end
            if (clr_load) begin
                ctrl_q.load <= 1'b0;
            end
            if (clr_run) begin
                ctrl_q.run <= 1'b0;
            end
            o_int_done <= clr_run;

            if (clr_cnt) begin
                idx      <= '0;
                word_off <= '0;
            end else begin
                if (inc_idx) begin
                    idx <= (idx == IDX_W'(NODES - 1)) ? '0 : idx + 1'b1;
                end
                if (inc_off) begin
                    word_off <= word_off + 1'b1;
                end
            end

            if (take_word) begin
                buf_vld <= 1'b0;
            end else if (state_q == ST_LOAD_WEIGHT && i_mem.rdy) begin
                buf_vld <= 1'b1;
            end

            if (o_node_rst) begin
                history <= '1;
            end else begin
                history <= {history[`PATH_QUIET-2:0], i_activity};
            end

            pend <= o_mem.req || (pend && !i_mem.rdy);
        end
    end

    always_ff @(posedge clk) begin
        if (take_word) begin
            data_word <= buf_vld ? rd_buf : i_mem.rdata;
        end else if (state_q == ST_PACK_DIR) begin
            data_word[idx[2:0]] <= i_node_dir;
        end
        if (state_q == ST_LOAD_WEIGHT && i_mem.rdy) begin
            rd_buf <= i_mem.rdata;
        end
    end

    // a new request may only overlap the response of the previous one
    a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        o_mem.req |-> !pend || i_mem.rdy);

    a_rdy_has_req: assert property (@(posedge clk) disable iff (!arst_n)
        i_mem.rdy |-> pend);

endmodule

// File: src/path_fabric.sv
`timescale 1ns/1ps
`include "path_config.svh"

module path_fabric (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                i_ctrl_wr,
    input  path_pkg::ctrl_t     i_ctrl,
    output path_pkg::ctrl_t     o_ctrl,
    output path_pkg::mem_req_t  o_mem,
    input  path_pkg::mem_rsp_t  i_mem,
    output logic                o_int_done
);

    localparam int IDX_W = $clog2(`PATH_DIM * `PATH_DIM);

    logic             node_rst;
    logic             start_clr;
    logic [4:0]       start_x;
    logic [4:0]       start_y;
    logic             ld;
    logic [IDX_W-1:0] node_idx;     // shared by load and direction readout
    logic [3:0]       ld_weight;
    logic             activity;
    path_pkg::dir_e   node_dir;

    path_sequencer i_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_ctrl_wr   (i_ctrl_wr),
        .i_ctrl      (i_ctrl),
        .o_ctrl      (o_ctrl),
        .o_mem       (o_mem),
        .i_mem       (i_mem),
        .o_int_done  (o_int_done),
        .o_node_rst  (node_rst),
        .o_start_clr (start_clr),
        .o_start_x   (start_x),
        .o_start_y   (start_y),
        .o_ld        (ld),
        .o_node_idx  (node_idx),
        .o_ld_weight (ld_weight),
        .i_activity  (activity),
        .i_node_dir  (node_dir)
    );

    path_grid #(
        .DIM (`PATH_DIM)
    ) i_grid (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_node_rst  (node_rst),
        .i_start_clr (start_clr),
        .i_start_x   (start_x),
        .i_start_y   (start_y),
        .i_ld        (ld),
        .i_node_idx  (node_idx),
        .i_ld_weight (ld_weight),
        .o_activity  (activity),
        .o_node_dir  (node_dir)
    );

endmodule

// File: dv/path_checker.sv
`timescale 1ns/1ps
`include "path_config.svh"

module path_checker (
    input  logic               clk,
    input  logic               i_ctrl_wr,
    input  path_pkg::ctrl_t    i_ctrl,
    input  path_pkg::ctrl_t    i_ctrl_rb,
    input  path_pkg::mem_req_t i_mem_req,
    input  path_pkg::mem_rsp_t i_mem_rsp,
    input  logic               i_int_done
);

    localparam int DIM   = `PATH_DIM;
    localparam int NODES = DIM * DIM;
    localparam int WORDS = NODES / 8;
    localparam int INF   = (1 << `PATH_COST_W) - 1;

    int          weight [NODES];
    int          exp_dir [NODES];
    logic [31:0] exp_word [WORDS];
    bit          run_on = 0;
    bit          load_on = 0;
    bit          rd_pend = 0;
    bit          wr_pend = 0;
    int          start_idx = 0;
    int          rd_word = 0;
    int          rd_cnt = 0;
    int          wr_cnt = 0;
    int          done_cnt = 0;
    int          req_total = 0;
    string       test_name = "none";
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          total_errs = 0;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errs);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic check_load();
        check_value("words read", WORDS, rd_cnt);
        load_on = 0;
    endtask

    task automatic check_run();
        check_value("words written", WORDS, wr_cnt);
        check_value("done pulses", 1, done_cnt);
        check_value("run bit", 0, i_ctrl_rb.run);
        check_value("start readback", start_idx,
                    int'(i_ctrl_rb.start_y) * DIM + int'(i_ctrl_rb.start_x));
    endtask

    // shortest path costs by relaxation, then cheapest neighbour per node
    function automatic void compute_model();
        int cost [NODES];
        int dx [8] = '{0, 1, 1, 1, 0, -1, -1, -1};
        int dy [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};
        bit changed;
        int m;
        int c;
        int nx;
        int ny;
        for (int i = 0; i < NODES; i++) cost[i] = INF;
        cost[start_idx] = 0;
        do begin
            changed = 0;
            for (int i = 0; i < NODES; i++) begin
                if (i != start_idx && weight[i] != path_pkg::WALL) begin
                    m = INF;
                    for (int d = 0; d < 8; d++) begin
                        nx = i % DIM + dx[d];
                        ny = i / DIM + dy[d];
                        if (nx >= 0 && nx < DIM && ny >= 0 && ny < DIM &&
                            cost[ny * DIM + nx] < m) m = cost[ny * DIM + nx];
                    end
                    if (m < INF) begin
                        c = (m + weight[i] > INF) ? INF : m + weight[i];
                        if (c != cost[i]) begin
                            cost[i] = c;
                            changed = 1;
                        end
                    end
                end
            end
        end while (changed);
        for (int i = 0; i < NODES; i++) begin
            exp_dir[i] = 0;
            if (i != start_idx && weight[i] != path_pkg::WALL && cost[i] != INF) begin
                m = INF;
                for (int d = 0; d < 8; d++) begin
                    nx = i % DIM + dx[d];
                    ny = i / DIM + dy[d];
                    if (nx >= 0 && nx < DIM && ny >= 0 && ny < DIM &&
                        cost[ny * DIM + nx] < m) begin
                        m = cost[ny * DIM + nx];
                        exp_dir[i] = d + 1;     // strict, lowest code wins
                    end
                end
            end
        end
        for (int i = 0; i < NODES; i++) exp_word[i / 8][4 * (i % 8) +: 4] = 4'(exp_dir[i]);
    endfunction

    // sample one step after the falling edge, all ports settled
    always begin
        @(negedge clk);
        #1;
        if (i_ctrl_wr && (!run_on || !i_ctrl.run)) begin
            start_idx = int'(i_ctrl.start_y) * DIM + int'(i_ctrl.start_x);
            if (i_ctrl.load) begin
                load_on = 1;
                rd_cnt  = 0;
            end
            if (i_ctrl.run) begin
                run_on   = 1;
                wr_cnt   = 0;
                done_cnt = 0;
                compute_model();
            end
        end
        if (i_mem_rsp.rdy) begin
            if (rd_pend && rd_word < WORDS) begin
                for (int j = 0; j < 8; j++)
                    weight[rd_word * 8 + j] = int'(i_mem_rsp.rdata[4 * j +: 4]);
            end
            rd_pend = 0;
            wr_pend = 0;
        end
        if (i_mem_req.req) begin
            req_total++;
            if (rd_pend || wr_pend) report_error("request issued while another is outstanding");
            if (i_mem_req.wr) begin
                if (!run_on) report_error("memory write issued outside a run");
                check_value("write address", `PATH_DIR_BASE + 4 * wr_cnt, i_mem_req.addr);
                if (wr_cnt < WORDS) check_value("direction word", exp_word[wr_cnt],
                                                i_mem_req.wdata);
                wr_cnt++;
                wr_pend = 1;
            end else begin
                if (!load_on) report_error("memory read issued outside a load");
                check_value("read address", `PATH_MAP_BASE + 4 * rd_cnt, i_mem_req.addr);
                rd_word = rd_cnt;
                rd_cnt++;
                rd_pend = 1;
            end
        end
        if (i_int_done) begin
            done_cnt++;
            run_on = 0;
        end
    end

endmodule

// File: dv/tb_path_fabric.sv
`timescale 1ns/1ps
`include "path_config.svh"

module tb_path_fabric;

    localparam int DIM       = `PATH_DIM;
    localparam int NODES     = DIM * DIM;
    localparam int WORDS     = NODES / 8;
    localparam int RUNS      = 9;
    localparam int LOAD_CYC  = WORDS * (8 + 8 + 2) + 4;      // delay, unpack, turnaround
    localparam int RELAX_CYC = NODES + `PATH_QUIET + 4;
    localparam int STORE_CYC = WORDS * (8 + 1 + 8 + 2) + 4;
    localparam int CYCLE_LIMIT = 2 * RUNS * (LOAD_CYC + RELAX_CYC + STORE_CYC) + 200;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               ctrl_wr;
    path_pkg::ctrl_t    ctrl;
    path_pkg::ctrl_t    ctrl_rb;
    path_pkg::mem_req_t mem_req;
    path_pkg::mem_rsp_t mem_rsp;
    logic               int_done;

    logic [31:0] map_mem [WORDS];
    logic [31:0] dir_mem [WORDS];
    logic [31:0] dir_save [WORDS];
    logic [3:0]  cells [NODES];
    logic [31:0] lfsr_q = 32'hd885_4bfe;
    logic [31:0] mem_rd_data;
    bit          mem_busy = 0;
    int          mem_cnt = 0;
    int          fixed_delay = 0;       // zero picks a random delay
    int          cycles = 0;
    int          sx, sy;

    path_fabric i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .i_ctrl_wr  (ctrl_wr),
        .i_ctrl     (ctrl),
        .o_ctrl     (ctrl_rb),
        .o_mem      (mem_req),
        .i_mem      (mem_rsp),
        .o_int_done (int_done)
    );

    path_checker i_chk (
        .clk        (clk),
        .i_ctrl_wr  (ctrl_wr),
        .i_ctrl     (ctrl),
        .i_ctrl_rb  (ctrl_rb),
        .i_mem_req  (mem_req),
        .i_mem_rsp  (mem_rsp),
        .i_int_done (int_done)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // one transfer at a time, rdy for a single cycle
    always begin
        @(negedge clk);
        mem_rsp.rdy = 1'b0;
        if (mem_busy) begin
            mem_cnt--;
            if (mem_cnt == 0) begin
                mem_rsp.rdy   = 1'b1;
                mem_rsp.rdata = mem_rd_data;
                mem_busy      = 0;
            end
        end
        #1;
        if (mem_req.req) begin
            mem_busy = 1;
            mem_cnt  = (fixed_delay != 0) ? fixed_delay : int'(rand_bits(3)) + 1;
            if (mem_req.wr) dir_mem[(mem_req.addr >> 2) % WORDS] = mem_req.wdata;
            else mem_rd_data = map_mem[(mem_req.addr >> 2) % WORDS];
        end
    end

    task automatic pack_map();
        for (int i = 0; i < NODES; i++) map_mem[i / 8][4 * (i % 8) +: 4] = cells[i];
    endtask

    task automatic fill_map();
        for (int i = 0; i < NODES; i++) begin
            if (rand_bits(3) == 0) cells[i] = path_pkg::WALL;    // about 1 in 8
            else cells[i] = 4'(1 + rand_bits(4) % 14);
        end
        pack_map();
    endtask

    task automatic write_ctrl(input logic run, input logic load, input int x, input int y);
        @(negedge clk);
        ctrl_wr       = 1'b1;
        ctrl          = '0;
        ctrl.run      = run;
        ctrl.load     = load;
        ctrl.start_x  = 5'(x);
        ctrl.start_y  = 5'(y);
        @(negedge clk);
        ctrl_wr = 1'b0;
        ctrl    = '0;
    endtask

    task automatic do_load();
        write_ctrl(1'b0, 1'b1, 0, 0);
        while (ctrl_rb.load) @(negedge clk);
        @(negedge clk);
        i_chk.check_load();
    endtask

    task automatic wait_done();
        while (!int_done) @(negedge clk);
        repeat (2) @(negedge clk);      // a stretched pulse shows up in the count
        i_chk.check_run();
    endtask

    task automatic load_and_run(input string name, input int x, input int y,
                                input bit enclose);
        i_chk.start_test(name);
        fill_map();
        if (enclose) begin
            for (int yy = y - 1; yy <= y + 1; yy++)
                for (int xx = x - 1; xx <= x + 1; xx++)
                    if (xx >= 0 && xx < DIM && yy >= 0 && yy < DIM && !(xx == x && yy == y))
                        cells[yy * DIM + xx] = path_pkg::WALL;
            pack_map();
        end
        do_load();
        write_ctrl(1'b1, 1'b0, x, y);
        wait_done();
        i_chk.finish_test();
    endtask

    initial begin
        arst_n  = 1'b0;
        ctrl_wr = 1'b0;
        ctrl    = '0;
        mem_rsp = '0;
        i_chk.start_test("reset state");
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        repeat (8) begin
            @(negedge clk);
            i_chk.check_value("control readback", 0, ctrl_rb);
            i_chk.check_value("done interrupt", 0, int_done);
        end
        i_chk.check_value("requests after reset", 0, i_chk.req_total);
        i_chk.finish_test();

        i_chk.start_test("map load");
        fill_map();
        do_load();
        i_chk.finish_test();

        i_chk.start_test("single run");
        write_ctrl(1'b1, 1'b0, int'(rand_bits(3)), int'(rand_bits(3)));
        wait_done();
        i_chk.finish_test();

        load_and_run("corner start", 0, 0, 0);
        load_and_run("far corner start", DIM - 1, DIM - 1, 0);
        load_and_run("enclosed start", 3, 4, 1);
        load_and_run("random start", int'(rand_bits(3)), int'(rand_bits(3)), 0);

        i_chk.start_test("run write while running");
        fill_map();
        do_load();
        sx = int'(rand_bits(3));
        sy = int'(rand_bits(3));
        write_ctrl(1'b1, 1'b0, sx, sy);
        repeat (3) @(negedge clk);
        write_ctrl(1'b1, 1'b0, DIM - 1 - sx, (sy + 3) % DIM);
        wait_done();
        i_chk.check_value("start x readback", sx, ctrl_rb.start_x);
        i_chk.check_value("start y readback", sy, ctrl_rb.start_y);
        i_chk.finish_test();

        i_chk.start_test("memory delay");
        fill_map();
        do_load();
        fixed_delay = 1;
        write_ctrl(1'b1, 1'b0, 2, 5);
        wait_done();
        for (int k = 0; k < WORDS; k++) dir_save[k] = dir_mem[k];
        fixed_delay = 8;
        write_ctrl(1'b1, 1'b0, 2, 5);
        wait_done();
        for (int k = 0; k < WORDS; k++)
            i_chk.check_value("same words at both delays", dir_save[k], dir_mem[k]);
        fixed_delay = 0;
        i_chk.finish_test();

        $display("tests run %0d, failed %0d, errors %0d",
                 i_chk.tests_run, i_chk.tests_failed, i_chk.total_errs);
        if (i_chk.tests_failed == 0 && i_chk.total_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: path_fabric.f
+incdir+src
src/path_pkg.sv
src/path_node.sv
src/path_grid.sv
src/path_sequencer.sv
src/path_fabric.sv
dv/path_checker.sv
dv/tb_path_fabric.sv

// File: Bender.yml
package:
  name: path_fabric

sources:
  - include_dirs:
      - src
    files:
      - src/path_pkg.sv
      - src/path_node.sv
      - src/path_grid.sv
      - src/path_sequencer.sv
      - src/path_fabric.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/path_checker.sv
      - dv/tb_path_fabric.sv
